// ==== rw_mgr.f ====
rw_mgr_pkg.sv
rw_mgr_program_ram.sv
rw_mgr_inst_seq.sv
rw_mgr_datapath.sv
rw_mgr_avl_slave.sv
rw_mgr_core.sv
rw_mgr_ddr3.sv
tb_clk_gen.sv
tb_rw_mgr.sv

// ==== rw_mgr_avl_slave.sv ====
// Avalon-MM slave of the read/write manager. Decodes the address map, holds the
// configuration registers and stalls non-status accesses while a program runs
`timescale 1ns/1ns
`default_nettype none

module rw_mgr_avl_slave (
	input  logic afi_clk,
	input  logic rst,
	input  logic [rw_mgr_pkg::AVL_ADDR_WIDTH-1:0] avl_address,
	input  logic avl_write,
	input  logic [rw_mgr_pkg::AVL_DATA_WIDTH-1:0] avl_writedata,
	input  logic avl_read,
	output logic [rw_mgr_pkg::AVL_DATA_WIDTH-1:0] avl_readdata,
	output logic avl_waitrequest,
	input  logic busy,
	input  logic [rw_mgr_pkg::NUM_BYTES-1:0] pass_flags,
	output logic ac_we,
	output logic [rw_mgr_pkg::AC_ADDR_WIDTH-1:0] ac_waddr,
	output logic [rw_mgr_pkg::AC_BUS_WIDTH-1:0] ac_wdata,
	output logic inst_we,
	output logic [rw_mgr_pkg::INST_ADDR_WIDTH-1:0] inst_waddr,
	output logic [rw_mgr_pkg::INST_WIDTH-1:0] inst_wdata,
	output logic run_start,
	output logic [rw_mgr_pkg::INST_ADDR_WIDTH-1:0] start_index,
	output logic [rw_mgr_pkg::CNT_WIDTH-1:0] cnt0_load,
	output logic [rw_mgr_pkg::CNT_WIDTH-1:0] cnt1_load,
	output logic [rw_mgr_pkg::AFI_DATA_WIDTH-1:0] pattern,
	output logic clear_pass
);
	import rw_mgr_pkg::*;

	logic wr_acc;
	logic rd_acc;
	logic [AVL_DATA_WIDTH-1:0] rd_mux;

	// Status stays readable during a run so the host can poll busy
	assign avl_waitrequest = busy && (avl_address != ADDR_STATUS);
	assign wr_acc = avl_write && !avl_waitrequest;
	assign rd_acc = avl_read && !avl_waitrequest;

	assign ac_we = wr_acc && (avl_address[AVL_ADDR_WIDTH-1:AC_ADDR_WIDTH] ==
		ADDR_AC_BASE[AVL_ADDR_WIDTH-1:AC_ADDR_WIDTH]);
	assign ac_waddr = avl_address[AC_ADDR_WIDTH-1:0];
	assign ac_wdata = avl_writedata[AC_BUS_WIDTH-1:0];

	assign inst_we = wr_acc && (avl_address[AVL_ADDR_WIDTH-1:INST_ADDR_WIDTH] ==
		ADDR_INST_BASE[AVL_ADDR_WIDTH-1:INST_ADDR_WIDTH]);
	assign inst_waddr = avl_address[INST_ADDR_WIDTH-1:0];
	assign inst_wdata = avl_writedata[INST_WIDTH-1:0];

	always_ff @(posedge afi_clk) begin
		if (rst) begin
			run_start <= 1'b0;
			clear_pass <= 1'b0;
			cnt0_load <= '0;
			cnt1_load <= '0;
			pattern <= '0;
		end else begin
			run_start <= wr_acc && (avl_address == ADDR_RUN);
			clear_pass <= wr_acc && (avl_address == ADDR_CLEAR);
			if (wr_acc && avl_address == ADDR_CNT0) begin
				cnt0_load <= avl_writedata[CNT_WIDTH-1:0];
			end
			if (wr_acc && avl_address == ADDR_CNT1) begin
				cnt1_load <= avl_writedata[CNT_WIDTH-1:0];
			end
			if (wr_acc && avl_address == ADDR_PATTERN) begin
				pattern <= avl_writedata[AFI_DATA_WIDTH-1:0];
			end
		end
	end

	// Tables are write-only from the host; their read ports belong to the sequencer
	always_comb begin
		rd_mux = '0;
		case (avl_address)
			ADDR_CNT0: rd_mux[CNT_WIDTH-1:0] = cnt0_load;
			ADDR_CNT1: rd_mux[CNT_WIDTH-1:0] = cnt1_load;
			ADDR_PATTERN: rd_mux[AFI_DATA_WIDTH-1:0] = pattern;
			ADDR_STATUS: rd_mux[NUM_BYTES:0] = {pass_flags, busy};
			default: rd_mux = '0;
		endcase
	end

	always_ff @(posedge afi_clk) begin
		if (wr_acc && avl_address == ADDR_RUN) begin
			start_index <= avl_writedata[INST_ADDR_WIDTH-1:0];
		end
		if (rd_acc) begin
			avl_readdata <= rd_mux;
		end
	end

	a_no_rw_overlap: assert property (
		@(posedge afi_clk) disable iff (rst) !(avl_write && avl_read)
	) else $error("Avalon read and write asserted together");

endmodule

`default_nettype wire

// ==== rw_mgr_cases.txt ====
# Command letter, then hex fields: T name, W addr data, R addr expected, D read word,
# E ras_n cas_n we_n address, G start, B start addr data, C idle check, I idle cycles
T reset_idle
C
R 44 1E
R 43 0
T issue_order
W 00 40D2123
W 01 4050400
W 02 40F0005
W 20 4020
W 21 4000
W 22 4040
W 23 0
E 0 1 0 400
E 0 1 1 123
E 1 1 1 005
G 0
T loop_count
W 41 3
W 28 4040
W 29 8008
W 2A 0
E 1 1 1 005
E 1 1 1 005
E 1 1 1 005
E 1 1 1 005
G 8
T write_data
W 43 A5C33C5A
W 03 5330010
W 2C 4060
W 2D 4040
W 2E 0
E 1 0 0 010
E 1 1 1 005
G C
T read_compare
W 04 4CB0020
W 30 4080
W 31 4080
W 32 0
D A5C3FF5A
D A5C33C5A
E 1 0 1 020
E 1 0 1 020
G 10
R 44 1A
W 45 0
I 2
R 44 1E
T busy_stall
W 41 6
W 34 8014
W 35 0
B 14 43 12345678
R 43 12345678
R 44 1E

// ==== rw_mgr_core.sv ====
// Generic read/write manager. Connects the Avalon slave, program tables,
// sequencer and datapath; memory-specific unpacking lives in the top level
`timescale 1ns/1ns
`default_nettype none

module rw_mgr_core (
	input  logic afi_clk,
	input  logic rst,
	input  logic [rw_mgr_pkg::AVL_ADDR_WIDTH-1:0] avl_address,
	input  logic avl_write,
	input  logic [rw_mgr_pkg::AVL_DATA_WIDTH-1:0] avl_writedata,
	input  logic avl_read,
	output logic [rw_mgr_pkg::AVL_DATA_WIDTH-1:0] avl_readdata,
	output logic avl_waitrequest,
	output logic [rw_mgr_pkg::AC_BUS_WIDTH-1:0] ac_bus,
	output logic [rw_mgr_pkg::AFI_DATA_WIDTH-1:0] afi_wdata,
	input  logic [rw_mgr_pkg::AFI_DATA_WIDTH-1:0] afi_rdata,
	input  logic afi_rdata_valid
);
	import rw_mgr_pkg::*;

	logic busy;
	logic [NUM_BYTES-1:0] pass_flags;
	logic ac_we;
	logic [AC_ADDR_WIDTH-1:0] ac_waddr;
	logic [AC_BUS_WIDTH-1:0] ac_wdata;
	logic inst_we;
	logic [INST_ADDR_WIDTH-1:0] inst_waddr;
	logic [INST_WIDTH-1:0] inst_wdata;
	logic run_start;
	logic [INST_ADDR_WIDTH-1:0] start_index;
	logic [CNT_WIDTH-1:0] cnt0_load;
	logic [CNT_WIDTH-1:0] cnt1_load;
	logic [AFI_DATA_WIDTH-1:0] pattern;
	logic clear_pass;
	logic [INST_ADDR_WIDTH-1:0] inst_rd_addr;
	logic [INST_WIDTH-1:0] inst_rd_data;
	logic [AC_ADDR_WIDTH-1:0] ac_rd_addr;
	logic [AC_BUS_WIDTH-1:0] ac_rd_data;

	rw_mgr_avl_slave i_avl_slave (
		.afi_clk(afi_clk), .rst(rst),
		.avl_address(avl_address), .avl_write(avl_write), .avl_writedata(avl_writedata),
		.avl_read(avl_read), .avl_readdata(avl_readdata),
		.avl_waitrequest(avl_waitrequest),
		.busy(busy), .pass_flags(pass_flags),
		.ac_we(ac_we), .ac_waddr(ac_waddr), .ac_wdata(ac_wdata),
		.inst_we(inst_we), .inst_waddr(inst_waddr), .inst_wdata(inst_wdata),
		.run_start(run_start), .start_index(start_index),
		.cnt0_load(cnt0_load), .cnt1_load(cnt1_load),
		.pattern(pattern), .clear_pass(clear_pass)
	);

	rw_mgr_program_ram i_program_ram (
		.afi_clk(afi_clk), .busy(busy),
		.ac_we(ac_we), .ac_waddr(ac_waddr), .ac_wdata(ac_wdata),
		.inst_we(inst_we), .inst_waddr(inst_waddr), .inst_wdata(inst_wdata),
		.ac_rd_addr(ac_rd_addr), .inst_rd_addr(inst_rd_addr),
		.ac_rd_data(ac_rd_data), .inst_rd_data(inst_rd_data)
	);

	rw_mgr_inst_seq i_inst_seq (
		.afi_clk(afi_clk), .rst(rst),
		.run_start(run_start), .start_index(start_index),
		.cnt0_load(cnt0_load), .cnt1_load(cnt1_load),
		.inst_rd_data(inst_rd_data), .ac_rd_data(ac_rd_data),
		.inst_rd_addr(inst_rd_addr), .ac_rd_addr(ac_rd_addr),
		.ac_bus(ac_bus), .busy(busy)
	);

	rw_mgr_datapath i_datapath (
		.afi_clk(afi_clk), .rst(rst),
		.ac_bus(ac_bus), .pattern(pattern), .clear_pass(clear_pass),
		.afi_rdata(afi_rdata), .afi_rdata_valid(afi_rdata_valid),
		.afi_wdata(afi_wdata), .pass_flags(pass_flags)
	);

endmodule

`default_nettype wire

// ==== rw_mgr_datapath.sv ====
// Write pattern drive and byte-wise read compare. The pass flags stay cleared
// after a mismatch until the host clears them
`timescale 1ns/1ns
`default_nettype none

module rw_mgr_datapath (
	input  logic afi_clk,
	input  logic rst,
	input  logic [rw_mgr_pkg::AC_BUS_WIDTH-1:0] ac_bus,
	input  logic [rw_mgr_pkg::AFI_DATA_WIDTH-1:0] pattern,
	input  logic clear_pass,
	input  logic [rw_mgr_pkg::AFI_DATA_WIDTH-1:0] afi_rdata,
	input  logic afi_rdata_valid,
	output logic [rw_mgr_pkg::AFI_DATA_WIDTH-1:0] afi_wdata,
	output logic [rw_mgr_pkg::NUM_BYTES-1:0] pass_flags
);
	import rw_mgr_pkg::*;

	logic [NUM_BYTES-1:0] byte_match;

	// Data follows the wdata_valid bit in the same cycle
	assign afi_wdata = ac_bus[AC_WDATA_VALID_BIT] ? pattern : '0;

	// Each DQ word of the returned beat against the same byte of the pattern
	always_comb begin
		for (int i = 0; i < NUM_BYTES; i++) begin
			byte_match[i] = afi_rdata[i*MEM_DQ_WIDTH +: MEM_DQ_WIDTH] ==
				pattern[i*MEM_DQ_WIDTH +: MEM_DQ_WIDTH];
		end
	end

	always_ff @(posedge afi_clk) begin
		if (rst || clear_pass) begin
			pass_flags <= '1;
		end else if (afi_rdata_valid) begin
			pass_flags <= pass_flags & byte_match;
		end
	end

endmodule

`default_nettype wire

// ==== rw_mgr_ddr3.sv ====
// DDR3 read/write manager top level. Unpacks the command bus onto half-rate AFI
// signals, with each field copied to both beats and every control lane
`timescale 1ns/1ns
`default_nettype none

module rw_mgr_ddr3 (
	input  logic afi_clk,
	input  logic rst,

	input  logic [rw_mgr_pkg::AVL_ADDR_WIDTH-1:0] avl_address,
	input  logic avl_write,
	input  logic [rw_mgr_pkg::AVL_DATA_WIDTH-1:0] avl_writedata,
	input  logic avl_read,
	output logic [rw_mgr_pkg::AVL_DATA_WIDTH-1:0] avl_readdata,
	output logic avl_waitrequest,

	output logic [rw_mgr_pkg::MEM_ADDRESS_WIDTH*rw_mgr_pkg::AFI_RATIO-1:0] afi_address,
	output logic [rw_mgr_pkg::MEM_BANK_WIDTH*rw_mgr_pkg::AFI_RATIO-1:0] afi_bank,
	output logic [rw_mgr_pkg::MEM_CS_WIDTH*rw_mgr_pkg::AFI_RATIO-1:0] afi_cs_n,
	output logic [rw_mgr_pkg::MEM_CKE_WIDTH*rw_mgr_pkg::AFI_RATIO-1:0] afi_cke,
	output logic [rw_mgr_pkg::MEM_ODT_WIDTH*rw_mgr_pkg::AFI_RATIO-1:0] afi_odt,
	output logic [rw_mgr_pkg::MEM_CONTROL_WIDTH*rw_mgr_pkg::AFI_RATIO-1:0] afi_ras_n,
	output logic [rw_mgr_pkg::MEM_CONTROL_WIDTH*rw_mgr_pkg::AFI_RATIO-1:0] afi_cas_n,
	output logic [rw_mgr_pkg::MEM_CONTROL_WIDTH*rw_mgr_pkg::AFI_RATIO-1:0] afi_we_n,
	output logic [rw_mgr_pkg::MEM_DQS_WIDTH*rw_mgr_pkg::AFI_RATIO-1:0] afi_dqs_en,
	output logic [rw_mgr_pkg::MEM_CONTROL_WIDTH*rw_mgr_pkg::AFI_RATIO-1:0] afi_mem_reset_n,
	output logic [rw_mgr_pkg::AFI_DATA_WIDTH-1:0] afi_wdata,
	output logic [rw_mgr_pkg::MEM_DQS_WIDTH*rw_mgr_pkg::AFI_RATIO-1:0] afi_wdata_valid,
	output logic afi_rdata_en,
	output logic afi_rdata_en_full,
	input  logic [rw_mgr_pkg::AFI_DATA_WIDTH-1:0] afi_rdata,
	input  logic afi_rdata_valid
);
	import rw_mgr_pkg::*;

	logic [AC_BUS_WIDTH-1:0] ac_bus;

	rw_mgr_core i_core (
		.afi_clk(afi_clk), .rst(rst),
		.avl_address(avl_address), .avl_write(avl_write), .avl_writedata(avl_writedata),
		.avl_read(avl_read), .avl_readdata(avl_readdata),
		.avl_waitrequest(avl_waitrequest),
		.ac_bus(ac_bus), .afi_wdata(afi_wdata),
		.afi_rdata(afi_rdata), .afi_rdata_valid(afi_rdata_valid)
	);

	assign afi_address = {AFI_RATIO{ac_bus[AC_ADDR_LSB +: MEM_ADDRESS_WIDTH]}};
	assign afi_bank = {AFI_RATIO{ac_bus[AC_BANK_LSB +: MEM_BANK_WIDTH]}};
	assign afi_cs_n = {(MEM_CS_WIDTH * AFI_RATIO){ac_bus[AC_CS_N_BIT]}};
	assign afi_cke = {(MEM_CKE_WIDTH * AFI_RATIO){ac_bus[AC_CKE_BIT]}};
	assign afi_odt = {(MEM_ODT_WIDTH * AFI_RATIO){ac_bus[AC_ODT_BIT]}};
	assign afi_ras_n = {(MEM_CONTROL_WIDTH * AFI_RATIO){ac_bus[AC_RAS_N_BIT]}};
	assign afi_cas_n = {(MEM_CONTROL_WIDTH * AFI_RATIO){ac_bus[AC_CAS_N_BIT]}};
	assign afi_we_n = {(MEM_CONTROL_WIDTH * AFI_RATIO){ac_bus[AC_WE_N_BIT]}};
	assign afi_mem_reset_n = {(MEM_CONTROL_WIDTH * AFI_RATIO){ac_bus[AC_MEM_RESET_N_BIT]}};

	// Upper dqs_en bit drives the second beat, lower bit the first
	assign afi_dqs_en = {{(MEM_DQS_WIDTH * AFI_RATIO / 2){ac_bus[AC_DQS_EN_LSB + 1]}},
		{(MEM_DQS_WIDTH * AFI_RATIO / 2){ac_bus[AC_DQS_EN_LSB]}}};

	assign afi_wdata_valid = {(MEM_DQS_WIDTH * AFI_RATIO){ac_bus[AC_WDATA_VALID_BIT]}};
	assign afi_rdata_en = ac_bus[AC_RDATA_EN_BIT];
	assign afi_rdata_en_full = ac_bus[AC_RDATA_EN_FULL_BIT];

endmodule

`default_nettype wire

// ==== rw_mgr_inst_seq.sv ====
// Instruction sequencer. Fetches one instruction every two cycles from the
// instruction table and places the indexed command word on the command bus
`timescale 1ns/1ns
`default_nettype none

module rw_mgr_inst_seq (
	input  logic afi_clk,
	input  logic rst,
	input  logic run_start,
	input  logic [rw_mgr_pkg::INST_ADDR_WIDTH-1:0] start_index,
	input  logic [rw_mgr_pkg::CNT_WIDTH-1:0] cnt0_load,
	input  logic [rw_mgr_pkg::CNT_WIDTH-1:0] cnt1_load,
	input  logic [rw_mgr_pkg::INST_WIDTH-1:0] inst_rd_data,
	input  logic [rw_mgr_pkg::AC_BUS_WIDTH-1:0] ac_rd_data,
	output logic [rw_mgr_pkg::INST_ADDR_WIDTH-1:0] inst_rd_addr,
	output logic [rw_mgr_pkg::AC_ADDR_WIDTH-1:0] ac_rd_addr,
	output logic [rw_mgr_pkg::AC_BUS_WIDTH-1:0] ac_bus,
	output logic busy
);
	import rw_mgr_pkg::*;

	seq_state_t state;
	rw_opcode_t opcode;
	// One spare bit so that running off the end of the table is visible
	logic [INST_ADDR_WIDTH:0] pc;
	logic [CNT_WIDTH-1:0] cnt0;
	logic [CNT_WIDTH-1:0] cnt1;
	logic cnt_sel;
	logic cnt_nonzero;
	logic [INST_ADDR_WIDTH-1:0] jump_target;
	logic issue_q;

	assign opcode = rw_opcode_t'(inst_rd_data[INST_OP_LSB +: OP_WIDTH]);
	assign cnt_sel = inst_rd_data[INST_CSEL_BIT];
	assign jump_target = inst_rd_data[INST_TGT_LSB +: INST_ADDR_WIDTH];
	assign cnt_nonzero = cnt_sel ? (cnt1 != '0) : (cnt0 != '0);

	// Instruction read is issued in S_FETCH, so its data is valid in S_EXEC
	assign inst_rd_addr = pc[INST_ADDR_WIDTH-1:0];

	// Command index is presented during S_EXEC and the word returns a cycle later
	assign ac_rd_addr = inst_rd_data[INST_IDX_LSB +: AC_ADDR_WIDTH];

	always_ff @(posedge afi_clk) begin
		if (rst) begin
			state <= S_IDLE;
			pc <= '0;
			cnt0 <= '0;
			cnt1 <= '0;
			issue_q <= 1'b0;
		end else begin
			issue_q <= 1'b0;
			case (state)
				S_IDLE: begin
					if (run_start) begin
						state <= S_FETCH;
						pc <= {1'b0, start_index};
						cnt0 <= cnt0_load;
						cnt1 <= cnt1_load;
					end
				end
				S_FETCH: begin
					state <= S_EXEC;
				end
				S_EXEC: begin
					state <= S_FETCH;
					case (opcode)
						OP_ISSUE: begin
							issue_q <= 1'b1;
							pc <= pc + 1'b1;
						end
						OP_JUMP: begin
							if (cnt_nonzero) begin
								pc <= {1'b0, jump_target};
								if (cnt_sel) begin
									cnt1 <= cnt1 - 1'b1;
								end else begin
									cnt0 <= cnt0 - 1'b1;
								end
							end else begin
								pc <= pc + 1'b1;
							end
						end
						// OP_END and any undefined opcode stop the program
						default: begin
							state <= S_IDLE;
						end
					endcase
				end
				default: begin
					state <= S_IDLE;
				end
			endcase
		end
	end

	// ac_rd_data is the RAM output register, so the bus comes straight from flops
	assign ac_bus = issue_q ? ac_rd_data : AC_IDLE;

	// Busy covers the start pulse too, closing the window before the FSM leaves idle
	assign busy = run_start || (state != S_IDLE);

	a_no_restart: assert property (
		@(posedge afi_clk) disable iff (rst) run_start |-> state == S_IDLE
	) else $error("run_start received while a program is running");

	a_pc_range: assert property (
		@(posedge afi_clk) disable iff (rst) (state != S_IDLE) |-> pc < INST_DEPTH
	) else $error("Program counter ran past the instruction table");

endmodule

`default_nettype wire

// ==== rw_mgr_pkg.sv ====
// Shared widths, Avalon address map, command-bus bit positions and enums for the
// DDR3 read/write manager. Every module imports what it needs from here
`default_nettype none

package rw_mgr_pkg;

	// Avalon slave
	localparam int AVL_ADDR_WIDTH = 8;
	localparam int AVL_DATA_WIDTH = 32;

	// Memory and AFI geometry, half rate with a single rank
	localparam int MEM_ADDRESS_WIDTH = 13;
	localparam int MEM_BANK_WIDTH = 3;
	localparam int MEM_DQ_WIDTH = 8;
	localparam int MEM_CONTROL_WIDTH = 1;
	localparam int MEM_CS_WIDTH = 1;
	localparam int MEM_CKE_WIDTH = 1;
	localparam int MEM_ODT_WIDTH = 1;
	localparam int MEM_DQS_WIDTH = 1;
	localparam int AFI_RATIO = 2;
	localparam int AFI_DATA_WIDTH = MEM_DQ_WIDTH * 2 * AFI_RATIO;
	localparam int NUM_BYTES = AFI_DATA_WIDTH / MEM_DQ_WIDTH;

	// Program tables
	localparam int AC_BUS_WIDTH = 28;
	localparam int AC_DEPTH = 32;
	localparam int AC_ADDR_WIDTH = $clog2(AC_DEPTH);
	localparam int INST_DEPTH = 32;
	localparam int INST_ADDR_WIDTH = $clog2(INST_DEPTH);
	localparam int INST_WIDTH = 16;
	localparam int CNT_WIDTH = 8;

	// Instruction fields: opcode, counter select, command index, jump target
	localparam int OP_WIDTH = 2;
	localparam int INST_OP_LSB = 14;
	localparam int INST_CSEL_BIT = 13;
	localparam int INST_IDX_LSB = 5;
	localparam int INST_TGT_LSB = 0;

	// Command-bus layout
	localparam int AC_ADDR_LSB = 0;
	localparam int AC_BANK_LSB = 13;
	localparam int AC_MEM_RESET_N_BIT = 16;
	localparam int AC_RAS_N_BIT = 17;
	localparam int AC_CAS_N_BIT = 18;
	localparam int AC_WE_N_BIT = 19;
	localparam int AC_DQS_EN_LSB = 20;
	localparam int AC_RDATA_EN_FULL_BIT = 22;
	localparam int AC_RDATA_EN_BIT = 23;
	localparam int AC_WDATA_VALID_BIT = 24;
	localparam int AC_ODT_BIT = 25;
	localparam int AC_CKE_BIT = 26;
	localparam int AC_CS_N_BIT = 27;

	// Deselect with cke and mem_reset_n held high
	localparam logic [AC_BUS_WIDTH-1:0] AC_IDLE = 28'hC0F0000;

	// Avalon word addresses
	localparam logic [AVL_ADDR_WIDTH-1:0] ADDR_AC_BASE = 8'h00;
	localparam logic [AVL_ADDR_WIDTH-1:0] ADDR_INST_BASE = 8'h20;
	localparam logic [AVL_ADDR_WIDTH-1:0] ADDR_RUN = 8'h40;
	localparam logic [AVL_ADDR_WIDTH-1:0] ADDR_CNT0 = 8'h41;
	localparam logic [AVL_ADDR_WIDTH-1:0] ADDR_CNT1 = 8'h42;
	localparam logic [AVL_ADDR_WIDTH-1:0] ADDR_PATTERN = 8'h43;
	localparam logic [AVL_ADDR_WIDTH-1:0] ADDR_STATUS = 8'h44;
	localparam logic [AVL_ADDR_WIDTH-1:0] ADDR_CLEAR = 8'h45;

	typedef enum logic [OP_WIDTH-1:0] {
		OP_END = 2'b00,
		OP_ISSUE = 2'b01,
		OP_JUMP = 2'b10
	} rw_opcode_t;

	typedef enum logic [1:0] {
		S_IDLE = 2'b00,
		S_FETCH = 2'b01,
		S_EXEC = 2'b10
	} seq_state_t;

endpackage

`default_nettype wire

// ==== rw_mgr_program_ram.sv ====
// Command table and instruction table, loaded by the Avalon slave and read
// synchronously by the sequencer with one cycle of latency
`timescale 1ns/1ns
`default_nettype none

module rw_mgr_program_ram (
	input  logic afi_clk,
	input  logic busy,
	input  logic ac_we,
	input  logic [rw_mgr_pkg::AC_ADDR_WIDTH-1:0] ac_waddr,
	input  logic [rw_mgr_pkg::AC_BUS_WIDTH-1:0] ac_wdata,
	input  logic inst_we,
	input  logic [rw_mgr_pkg::INST_ADDR_WIDTH-1:0] inst_waddr,
	input  logic [rw_mgr_pkg::INST_WIDTH-1:0] inst_wdata,
	input  logic [rw_mgr_pkg::AC_ADDR_WIDTH-1:0] ac_rd_addr,
	input  logic [rw_mgr_pkg::INST_ADDR_WIDTH-1:0] inst_rd_addr,
	output logic [rw_mgr_pkg::AC_BUS_WIDTH-1:0] ac_rd_data,
	output logic [rw_mgr_pkg::INST_WIDTH-1:0] inst_rd_data
);
	import rw_mgr_pkg::*;

	logic [AC_BUS_WIDTH-1:0] ac_mem [AC_DEPTH];
	logic [INST_WIDTH-1:0] inst_mem [INST_DEPTH];

	always_ff @(posedge afi_clk) begin
		if (ac_we) begin
			ac_mem[ac_waddr] <= ac_wdata;
		end
		ac_rd_data <= ac_mem[ac_rd_addr];
	end

	always_ff @(posedge afi_clk) begin
		if (inst_we) begin
			inst_mem[inst_waddr] <= inst_wdata;
		end
		inst_rd_data <= inst_mem[inst_rd_addr];
	end

	// The slave stalls table writes with waitrequest while a program runs
	a_no_write_while_busy: assert property (
		@(posedge afi_clk) busy |-> !(ac_we || inst_we)
	) else $error("Program table written while the sequencer is running");

endmodule

`default_nettype wire

// ==== tb_clk_gen.sv ====
// Free-running testbench clock with an 8 ns period
`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen (
	output logic clk
);

	initial begin
		clk = 1'b0;
	end

	always begin
		#4 clk = ~clk;
	end

endmodule

`default_nettype wire

// ==== tb_rw_mgr.sv ====
// Testbench for the DDR3 read/write manager. Runs the commands in rw_mgr_cases.txt,
// returns read data like a memory would and checks the AFI and Avalon responses
`timescale 1ns/1ns
`default_nettype none

module tb_rw_mgr;

	localparam int TIMEOUT = 200;
	localparam logic [7:0] ADDR_RUN = 8'h40;
	localparam logic [7:0] ADDR_PATTERN = 8'h43;
	localparam logic [7:0] ADDR_STATUS = 8'h44;

	logic clk;
	logic rst;
	logic [7:0] avl_address;
	logic avl_write;
	logic [31:0] avl_writedata;
	logic avl_read;
	logic [31:0] avl_readdata;
	logic avl_waitrequest;
	logic [25:0] afi_address;
	logic [5:0] afi_bank;
	logic [1:0] afi_cs_n;
	logic [1:0] afi_cke;
	logic [1:0] afi_odt;
	logic [1:0] afi_ras_n;
	logic [1:0] afi_cas_n;
	logic [1:0] afi_we_n;
	logic [1:0] afi_dqs_en;
	logic [1:0] afi_mem_reset_n;
	logic [31:0] afi_wdata;
	logic [1:0] afi_wdata_valid;
	logic afi_rdata_en;
	logic afi_rdata_en_full;
	logic [31:0] afi_rdata;
	logic afi_rdata_valid;

	// Each issued command as {ras_n, cas_n, we_n, address}
	logic [15:0] got_q[$];
	logic [15:0] exp_q[$];
	logic [31:0] ret_q[$];
	logic [3:0] rd_pipe;
	logic [31:0] rng_state;
	logic [31:0] exp_pattern;
	logic timed_out;
	int errors;
	int case_errors;
	int cases_run;
	int cases_failed;
	string cur_name;

	tb_clk_gen i_clk_gen (
		.clk(clk)
	);

	rw_mgr_ddr3 i_dut (
		.afi_clk(clk), .rst(rst),
		.avl_address(avl_address), .avl_write(avl_write), .avl_writedata(avl_writedata),
		.avl_read(avl_read), .avl_readdata(avl_readdata),
		.avl_waitrequest(avl_waitrequest),
		.afi_address(afi_address), .afi_bank(afi_bank), .afi_cs_n(afi_cs_n),
		.afi_cke(afi_cke), .afi_odt(afi_odt), .afi_ras_n(afi_ras_n),
		.afi_cas_n(afi_cas_n), .afi_we_n(afi_we_n), .afi_dqs_en(afi_dqs_en),
		.afi_mem_reset_n(afi_mem_reset_n), .afi_wdata(afi_wdata),
		.afi_wdata_valid(afi_wdata_valid), .afi_rdata_en(afi_rdata_en),
		.afi_rdata_en_full(afi_rdata_en_full), .afi_rdata(afi_rdata),
		.afi_rdata_valid(afi_rdata_valid)
	);

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// Memory model, returns the next queued word four cycles after each rdata_en
	always @(negedge clk) begin
		rng_state = lcg_next(rng_state);
		if (rst) begin
			rd_pipe <= '0;
			afi_rdata_valid <= 1'b0;
			afi_rdata <= rng_state;
		end else begin
			rd_pipe <= {rd_pipe[2:0], afi_rdata_en};
			afi_rdata_valid <= rd_pipe[3];
			if (rd_pipe[3] && ret_q.size() > 0) begin
				afi_rdata <= ret_q.pop_front();
			end else begin
				afi_rdata <= rng_state;
				if (rd_pipe[3]) begin
					$display("memory model was asked for read data but none was queued");
					errors++;
					case_errors++;
				end
			end
		end
	end

	task automatic report_mismatch(input string msg);
		$display("error %0t: %0s", $time, msg);
		errors++;
		case_errors++;
	endtask

	task automatic close_case();
		if (cur_name != "") begin
			if (case_errors == 0) begin
				$display("case %0s: ok", cur_name);
			end else begin
				$display("case %0s: %0d error(s)", cur_name, case_errors);
				cases_failed++;
			end
			cases_run++;
		end
		case_errors = 0;
	endtask

	// All bus tasks start and end on a falling edge
	task automatic bus_write(input logic [7:0] addr, input logic [31:0] data, output int waits);
		int t;
		t = 0;
		avl_address = addr;
		avl_writedata = data;
		avl_write = 1'b1;
		#1;
		while (avl_waitrequest && t < TIMEOUT) begin
			@(negedge clk);
			#1;
			t++;
		end
		waits = t;
		if (avl_waitrequest) begin
			$display("write to address %0h was still held by waitrequest at the timeout", addr);
			errors++;
			case_errors++;
			timed_out = 1'b1;
		end
		@(negedge clk);
		avl_write = 1'b0;
		if (addr == ADDR_PATTERN) begin
			exp_pattern = data;
		end
	endtask

	task automatic bus_read(input logic [7:0] addr, output logic [31:0] data);
		int t;
		t = 0;
		avl_address = addr;
		avl_read = 1'b1;
		#1;
		while (avl_waitrequest && t < TIMEOUT) begin
			@(negedge clk);
			#1;
			t++;
		end
		if (avl_waitrequest) begin
			$display("read of address %0h was still held by waitrequest at the timeout", addr);
			errors++;
			case_errors++;
			timed_out = 1'b1;
		end
		@(negedge clk);
		avl_read = 1'b0;
		data = avl_readdata;
	endtask

	task automatic check_idle();
		if (afi_cs_n !== 2'b11 || afi_cke !== 2'b11 || afi_ras_n !== 2'b11 ||
			afi_cas_n !== 2'b11 || afi_we_n !== 2'b11 || afi_mem_reset_n !== 2'b11 ||
			afi_odt !== 2'b00 || afi_dqs_en !== 2'b00 || afi_wdata_valid !== 2'b00 ||
			afi_rdata_en !== 1'b0 || afi_rdata_en_full !== 1'b0 ||
			afi_address !== '0 || afi_bank !== '0) begin
			report_mismatch($sformatf("AFI not idle: cs_n %b ras_n %b cas_n %b we_n %b cke %b",
				afi_cs_n, afi_ras_n, afi_cas_n, afi_we_n, afi_cke));
		end
	endtask

	task automatic sample_afi();
		if (afi_cs_n === 2'b00) begin
			if (afi_address[25:13] !== afi_address[12:0] || afi_bank[5:3] !== afi_bank[2:0] ||
				afi_ras_n[1] !== afi_ras_n[0] || afi_cas_n[1] !== afi_cas_n[0] ||
				afi_we_n[1] !== afi_we_n[0]) begin
				report_mismatch($sformatf("command differs between beats, address %h", afi_address));
			end
			got_q.push_back({afi_ras_n[0], afi_cas_n[0], afi_we_n[0], afi_address[12:0]});
		end else if (afi_cs_n !== 2'b11) begin
			report_mismatch($sformatf("cs_n lanes disagree: %b", afi_cs_n));
		end
		if (afi_wdata_valid !== 2'b00) begin
			if (afi_wdata_valid !== 2'b11 || afi_wdata !== exp_pattern) begin
				report_mismatch($sformatf("write data %h valid %b, expected %h on both lanes",
					afi_wdata, afi_wdata_valid, exp_pattern));
			end
		end else if (afi_wdata !== '0) begin
			report_mismatch($sformatf("write data %h driven without wdata_valid", afi_wdata));
		end
	endtask

	// Polls status every cycle until busy has fallen and all read returns are done
	task automatic run_program(input logic [4:0] start);
		int t;
		int i;
		int waits;
		logic done;
		bus_write(ADDR_RUN, {27'd0, start}, waits);
		avl_address = ADDR_STATUS;
		avl_read = 1'b1;
		sample_afi();
		t = 0;
		done = 1'b0;
		while (!done && t < TIMEOUT) begin
			@(negedge clk);
			t++;
			sample_afi();
			done = !avl_readdata[0] && rd_pipe == '0 && !afi_rdata_valid;
		end
		avl_read = 1'b0;
		if (!done) begin
			$display("program starting at %0d did not finish before the timeout", start);
			errors++;
			case_errors++;
			timed_out = 1'b1;
		end
		if (got_q.size() != exp_q.size()) begin
			report_mismatch($sformatf("%0d commands issued, %0d expected",
				got_q.size(), exp_q.size()));
		end
		for (i = 0; i < got_q.size() && i < exp_q.size(); i++) begin
			if (got_q[i] !== exp_q[i]) begin
				report_mismatch($sformatf("command %0d is %h, expected %h", i, got_q[i], exp_q[i]));
			end
		end
		got_q.delete();
		exp_q.delete();
	endtask

	task automatic stall_check(input logic [4:0] start, input logic [7:0] addr,
		input logic [31:0] data);
		int waits;
		logic [31:0] status;
		bus_write(ADDR_RUN, {27'd0, start}, waits);
		bus_read(ADDR_STATUS, status);
		if (status[0] !== 1'b1) begin
			report_mismatch($sformatf("status %h shows busy clear during a run", status));
		end
		bus_write(addr, data, waits);
		if (waits == 0) begin
			report_mismatch($sformatf("write to %h during a run was not held", addr));
		end
	endtask

	task automatic run_line(input string line);
		string cmd;
		int n;
		int waits;
		logic [31:0] f0, f1, f2, f3;
		logic [31:0] rd;
		n = $sscanf(line, "%s %h %h %h %h", cmd, f0, f1, f2, f3);
		if (cmd == "T") begin
			close_case();
			n = $sscanf(line, "%s %s", cmd, cur_name);
		end else if (cmd == "W") begin
			bus_write(f0[7:0], f1, waits);
		end else if (cmd == "R") begin
			bus_read(f0[7:0], rd);
			if (rd !== f1) begin
				report_mismatch($sformatf("read of %h returned %h, expected %h", f0[7:0], rd, f1));
			end
		end else if (cmd == "D") begin
			ret_q.push_back(f0);
		end else if (cmd == "E") begin
			exp_q.push_back({f0[0], f1[0], f2[0], f3[12:0]});
		end else if (cmd == "G") begin
			run_program(f0[4:0]);
		end else if (cmd == "B") begin
			stall_check(f0[4:0], f1[7:0], f2);
		end else if (cmd == "C") begin
			check_idle();
		end else if (cmd == "I") begin
			repeat (f0) @(negedge clk);
		end else begin
			$display("unknown command %0s in the cases file", cmd);
			errors++;
			case_errors++;
		end
	endtask

	initial begin
		int fd;
		int n;
		string line;
		rst = 1'b1;
		avl_address = '0;
		avl_write = 1'b0;
		avl_writedata = '0;
		avl_read = 1'b0;
		afi_rdata = '0;
		afi_rdata_valid = 1'b0;
		rng_state = 32'd18;
		exp_pattern = '0;
		timed_out = 1'b0;
		errors = 0;
		case_errors = 0;
		cases_run = 0;
		cases_failed = 0;
		cur_name = "";
		fd = $fopen("rw_mgr_cases.txt", "r");
		if (fd == 0) begin
			$display("could not open rw_mgr_cases.txt");
			errors++;
		end
		repeat (16) @(negedge clk);
		rst = 1'b0;
		while (fd != 0 && !$feof(fd) && !timed_out) begin
			n = $fgets(line, fd);
			if (n > 1 && line.getc(0) != "#") begin
				run_line(line);
			end
		end
		close_case();
		if (fd != 0) begin
			$fclose(fd);
		end
		$display("cases run %0d, cases failed %0d, errors %0d", cases_run, cases_failed, errors);
		if (errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
